// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f filelist.f --top-module hart_tb -o hart_sim
	./obj_dir/hart_sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/hart_tb_program.svh ====
/*
  Program rows in execution order, body of the program loader task.
  Skipped slots behind taken branches stay as nops.
*/
// ALU register and immediate forms
add_reg_row(0,  enc_i(5, 0, 0, 1, 7'h13), 1, 32'd5);                 // addi x1 = 5
add_reg_row(4,  enc_i(-3, 0, 0, 2, 7'h13), 2, 32'hFFFF_FFFD);        // addi x2 = -3
add_reg_row(8,  enc_r(7'h00, 2, 1, 0, 3), 3, 32'd2);                 // add
add_reg_row(12, enc_r(7'h20, 2, 1, 0, 4), 4, 32'd8);                 // sub
add_reg_row(16, enc_r(7'h00, 1, 1, 1, 5), 5, 32'd160);               // sll
add_reg_row(20, enc_r(7'h00, 1, 2, 2, 6), 6, 32'd1);                 // slt
add_reg_row(24, enc_r(7'h00, 1, 2, 3, 7), 7, 32'd0);                 // sltu
add_reg_row(28, enc_r(7'h00, 2, 1, 4, 8), 8, 32'hFFFF_FFF8);         // xor
add_reg_row(32, enc_i(32'h401, 2, 5, 9, 7'h13), 9, 32'hFFFF_FFFE);   // srai 1
add_reg_row(36, enc_i(28, 2, 5, 10, 7'h13), 10, 32'h0000_000F);      // srli 28
add_reg_row(40, enc_i(32'h30, 1, 6, 11, 7'h13), 11, 32'h35);         // ori
add_reg_row(44, enc_i(32'hF0, 2, 7, 12, 7'h13), 12, 32'hF0);         // andi
add_reg_row(48, enc_i(0, 2, 2, 13, 7'h13), 13, 32'd1);               // slti
add_reg_row(52, enc_i(-1, 1, 3, 14, 7'h13), 14, 32'd1);              // sltiu
add_reg_row(56, enc_i(7, 1, 0, 0, 7'h13), 0, 32'd0);                 // x0 write dropped
add_reg_row(60, enc_r(7'h00, 0, 0, 0, 15), 15, 32'd0);               // x0 reads zero
add_reg_row(64, enc_u(20'h12345, 16, 7'h37), 16, 32'h1234_5000);     // lui
add_reg_row(68, enc_u(20'h00001, 17, 7'h17), 17, 32'h0000_1044);     // auipc
// Each branch taken then not taken
add_flow_row(72,  enc_b(8, 1, 1, 0), 0, 0, 80);                      // beq
add_flow_row(80,  enc_b(8, 2, 1, 0), 0, 0, 84);
add_flow_row(84,  enc_b(8, 2, 1, 1), 0, 0, 92);                      // bne
add_flow_row(92,  enc_b(8, 1, 1, 1), 0, 0, 96);
add_flow_row(96,  enc_b(8, 1, 2, 4), 0, 0, 104);                     // blt
add_flow_row(104, enc_b(8, 2, 1, 4), 0, 0, 108);
add_flow_row(108, enc_b(8, 2, 1, 5), 0, 0, 116);                     // bge
add_flow_row(116, enc_b(8, 1, 2, 5), 0, 0, 120);
add_flow_row(120, enc_b(8, 2, 1, 6), 0, 0, 128);                     // bltu
add_flow_row(128, enc_b(8, 1, 2, 6), 0, 0, 132);
add_flow_row(132, enc_b(8, 1, 2, 7), 0, 0, 140);                     // bgeu
add_flow_row(140, enc_b(8, 2, 1, 7), 0, 0, 144);
// Jumps, JALR target 169 has bit 0 cleared
add_flow_row(144, enc_j(12, 18), 18, 32'd148, 156);                  // jal
add_reg_row(156, enc_i(165, 0, 0, 19, 7'h13), 19, 32'd165);
add_flow_row(160, enc_i(4, 19, 0, 20, 7'h67), 20, 32'd164, 168);     // jalr
// Stores then loads around 0x100
add_reg_row(168, enc_i(32'h100, 0, 0, 21, 7'h13), 21, 32'h100);
add_reg_row(172, enc_u(20'h89ABD, 22, 7'h37), 22, 32'h89AB_D000);
add_reg_row(176, enc_i(-529, 22, 0, 22, 7'h13), 22, 32'h89AB_CDEF);
add_row(180, enc_s(0, 22, 21, 2), 0, 0, 184, 2, 32'h100, 4'b1111, 32'h89AB_CDEF);  // sw
add_row(184, enc_s(5, 1, 21, 0), 0, 0, 188, 2, 32'h104, 4'b0010, 32'h0000_0500);   // sb
add_row(188, enc_s(6, 22, 21, 1), 0, 0, 192, 2, 32'h104, 4'b1100, 32'hCDEF_0000);  // sh
add_row(192, enc_i(3, 21, 0, 23, 7'h03), 23, 32'hFFFF_FF89, 196, 1, 32'h100, 4'b1000, 0);
add_row(196, enc_i(3, 21, 4, 24, 7'h03), 24, 32'h89, 200, 1, 32'h100, 4'b1000, 0);
add_row(200, enc_i(6, 21, 1, 25, 7'h03), 25, 32'hFFFF_CDEF, 204, 1, 32'h104, 4'b1100, 0);
add_row(204, enc_i(4, 21, 5, 26, 7'h03), 26, 32'h541, 208, 1, 32'h104, 4'b0011, 0);
add_row(208, enc_i(0, 21, 2, 27, 7'h03), 27, 32'h89AB_CDEF, 212, 1, 32'h100, 4'b1111, 0);
add_row(212, enc_i(5, 21, 0, 28, 7'h03), 28, 32'h05, 216, 1, 32'h104, 4'b0010, 0);
// ebreak parks the pc
add_flow_row(216, EBREAK, 0, 0, 216);
add_flow_row(216, EBREAK, 0, 0, 216);
add_flow_row(216, EBREAK, 0, 0, 216);

// ==== dv/hart_tb.sv ====
/*
  Table-driven testbench for the single-cycle hart. One table row is checked per cycle.
  Instruction and data memories are 256 words, indexed by address bits 9:2.
*/
`timescale 1ns/1ps

module hart_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  rd;       // Zero when no register is written
        logic [31:0] rd_data;
        logic [31:0] next_pc;
        logic [1:0]  acc;      // 0 none, 1 load, 2 store
        logic [31:0] addr;     // Word-aligned data address
        logic [3:0]  mask;
        logic [31:0] wdata;
    } row_t;

    localparam logic [31:0] EBREAK = 32'h0010_0073;
    localparam logic [31:0] NOP    = 32'h0000_0013;  // addi x0, x0, 0

    logic                clk;
    logic                rst_n;
    logic [31:0]         imem_raddr;
    logic [31:0]         imem_rdata;
    hart_pkg::dmem_req_t dmem_req;
    logic [31:0]         dmem_rdata;
    hart_pkg::retire_t   retire;
    logic [31:0]         imem [0:255];
    logic [31:0]         dmem [0:255];
    row_t                rows [$];

    hart_top i_hart_top (
        .clk, .rst_n, .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
        .o_dmem_req(dmem_req), .i_dmem_rdata(dmem_rdata), .o_retire(retire)
    );

    assign imem_rdata = imem[imem_raddr[9:2]];  // Same-cycle fetch
    assign dmem_rdata = dmem_req.ren ? dmem[dmem_req.addr[9:2]] : 32'h0;

    always @(posedge clk) begin
        if (dmem_req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.mask[b])
                    dmem[dmem_req.addr[9:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32I encoders, fields laid out as in the ISA manual
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    task automatic add_row(logic [31:0] pc, logic [31:0] inst, logic [4:0] rd,
                           logic [31:0] data, logic [31:0] next_pc, logic [1:0] acc,
                           logic [31:0] addr, logic [3:0] mask, logic [31:0] wdata);
        rows.push_back({pc, inst, rd, data, next_pc, acc, addr, mask, wdata});
        imem[pc[9:2]] = inst;
    endtask

    // Straight-line ALU row, no data access
    task automatic add_reg_row(logic [31:0] pc, logic [31:0] inst, logic [4:0] rd,
                               logic [31:0] data);
        add_row(pc, inst, rd, data, pc + 32'd4, 2'd0, 32'h0, 4'h0, 32'h0);
    endtask

    // Branch or jump row
    task automatic add_flow_row(logic [31:0] pc, logic [31:0] inst, logic [4:0] rd,
                                logic [31:0] data, logic [31:0] next_pc);
        add_row(pc, inst, rd, data, next_pc, 2'd0, 32'h0, 4'h0, 32'h0);
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP;
            dmem[i] = 32'hC0DE_0000 | i;  // Word index in the low bits
        end
`include "hart_tb_program.svh"
    endtask

    task automatic report_mismatch(string what);
        $display("Mismatch at time %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic check_row(row_t r);
        assert (retire.valid) else report_mismatch("retire valid low");
        assert (imem_raddr == r.pc)
            else report_mismatch($sformatf("imem address %h, expected %h", imem_raddr, r.pc));
        assert (retire.pc == r.pc)
            else report_mismatch($sformatf("pc %h, expected %h", retire.pc, r.pc));
        assert (retire.inst == r.inst)
            else report_mismatch($sformatf("inst %h, expected %h", retire.inst, r.inst));
        assert (retire.next_pc == r.next_pc)
            else report_mismatch($sformatf("next pc %h, expected %h at pc %h",
                                           retire.next_pc, r.next_pc, r.pc));
        assert (retire.halt == (r.inst == EBREAK))
            else report_mismatch($sformatf("halt %b at pc %h", retire.halt, r.pc));
        assert (retire.rd_waddr == r.rd)
            else report_mismatch($sformatf("rd %0d, expected %0d at pc %h",
                                           retire.rd_waddr, r.rd, r.pc));
        if (r.rd != 5'd0)
            assert (retire.rd_wdata == r.rd_data)
                else report_mismatch($sformatf("rd data %h, expected %h at pc %h",
                                               retire.rd_wdata, r.rd_data, r.pc));
        assert (dmem_req.ren == (r.acc == 2'd1) && dmem_req.wen == (r.acc == 2'd2))
            else report_mismatch($sformatf("ren/wen %b%b at pc %h",
                                           dmem_req.ren, dmem_req.wen, r.pc));
        if (r.acc != 2'd0)
            assert (dmem_req.addr == r.addr && dmem_req.mask == r.mask)
                else report_mismatch($sformatf("addr %h mask %b, expected %h %b",
                                               dmem_req.addr, dmem_req.mask, r.addr, r.mask));
        if (r.acc == 2'd2)
            assert (dmem_req.wdata == r.wdata)
                else report_mismatch($sformatf("wdata %h, expected %h",
                                               dmem_req.wdata, r.wdata));
    endtask

    initial begin
        int wait_cycles;
        rst_n = 1'b1;  // Reset level is high
        load_program();
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b0;
        @(negedge clk);
        wait_cycles = 0;
        while (!retire.valid) begin
            if (wait_cycles > 20) begin
                $display("Retire valid did not rise within 20 cycles after reset");
                $display("STATUS: FAIL");
                $fatal(1, "Timeout waiting for retire valid");
            end
            wait_cycles++;
            @(negedge clk);
        end
        foreach (rows[i]) begin
            check_row(rows[i]);  // Mid-cycle, all outputs settled
            @(negedge clk);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+dv
source/hart_pkg.sv
source/hart_decode.sv
source/hart_regfile.sv
source/hart_fetch.sv
source/hart_execute.sv
source/hart_lsu.sv
source/hart_result.sv
source/hart_top.sv
dv/hart_tb.sv

// ==== source/hart_decode.sv ====
/*
  Instruction decode. Unknown opcodes come out as no-ops.
  Only the exact ebreak encoding raises halt.
*/
`timescale 1ns/1ps

module hart_decode (
    input  logic [hart_pkg::XLEN-1:0] i_inst,
    output hart_pkg::ctrl_t           o_ctrl,
    output logic [hart_pkg::XLEN-1:0] o_imm
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    hart_pkg::alu_op_e arith_op;
    hart_pkg::size_e   mem_size;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign funct7_b5 = i_inst[30];  // sub and sra select

    // funct3 to ALU op, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == hart_pkg::OPC_OP && funct7_b5) ?
                                hart_pkg::ALU_SUB : hart_pkg::ALU_ADD;  // No subi
            3'b001:  arith_op = hart_pkg::ALU_SLL;
            3'b010:  arith_op = hart_pkg::ALU_SLT;
            3'b011:  arith_op = hart_pkg::ALU_SLTU;
            3'b100:  arith_op = hart_pkg::ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
            3'b110:  arith_op = hart_pkg::ALU_OR;
            default: arith_op = hart_pkg::ALU_AND;
        endcase
    end

    assign mem_size = funct3[1] ? hart_pkg::SIZE_WORD :
                      (funct3[0] ? hart_pkg::SIZE_HALF : hart_pkg::SIZE_BYTE);

    always_comb begin
        o_ctrl = '0;  // add, rs1, no writes
        o_imm  = {{20{i_inst[31]}}, i_inst[31:20]};  // I form unless overridden
        case (opcode)
            hart_pkg::OPC_OP: begin
                o_ctrl.alu_op = arith_op;
                o_ctrl.rd_wen = 1'b1;
            end
            hart_pkg::OPC_OP_IMM: begin
                o_ctrl.alu_op      = arith_op;
                o_ctrl.op_b_is_imm = 1'b1;
                o_ctrl.rd_wen      = 1'b1;
            end
            hart_pkg::OPC_LUI, hart_pkg::OPC_AUIPC: begin
                o_ctrl.op_a_sel    = (opcode == hart_pkg::OPC_LUI) ?
                                     hart_pkg::OPA_ZERO : hart_pkg::OPA_PC;
                o_ctrl.op_b_is_imm = 1'b1;
                o_ctrl.rd_wen      = 1'b1;
                o_imm              = {i_inst[31:12], 12'b0};
            end
            hart_pkg::OPC_BRANCH: begin
                o_ctrl.alu_op    = funct3[1] ? hart_pkg::ALU_SLTU : hart_pkg::ALU_SLT;
                o_ctrl.is_branch = 1'b1;
                o_ctrl.br_funct3 = funct3;
                o_imm            = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                                    i_inst[30:25], i_inst[11:8], 1'b0};
            end
            hart_pkg::OPC_JAL, hart_pkg::OPC_JALR: begin
                o_ctrl.op_a_sel = hart_pkg::OPA_PC_PLUS_4;  // Link value
                o_ctrl.is_jal   = (opcode == hart_pkg::OPC_JAL);
                o_ctrl.is_jalr  = (opcode == hart_pkg::OPC_JALR);
                o_ctrl.rd_wen   = 1'b1;
                if (opcode == hart_pkg::OPC_JAL)
                    o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                             i_inst[20], i_inst[30:21], 1'b0};
            end
            hart_pkg::OPC_LOAD: begin
                o_ctrl.op_b_is_imm   = 1'b1;
                o_ctrl.mem_ren       = 1'b1;
                o_ctrl.size          = mem_size;
                o_ctrl.load_unsigned = funct3[2];
                o_ctrl.rd_wen        = 1'b1;
            end
            hart_pkg::OPC_STORE: begin
                o_ctrl.op_b_is_imm = 1'b1;
                o_ctrl.mem_wen     = 1'b1;
                o_ctrl.size        = mem_size;
                o_imm              = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            end
            hart_pkg::OPC_SYSTEM: o_ctrl.halt = (i_inst[31:7] == 25'h000_2000);  // ebreak
            default: ;  // No-op
        endcase
    end

endmodule

// ==== source/hart_execute.sv ====
/*
  Operand muxing, ALU and branch decision, all combinational.
  Branches rely on decode choosing slt or sltu for the compare.
*/
`timescale 1ns/1ps

module hart_execute (
    input  hart_pkg::ctrl_t           i_ctrl,
    input  logic [hart_pkg::XLEN-1:0] i_pc,
    input  logic [hart_pkg::XLEN-1:0] i_imm,
    input  logic [hart_pkg::XLEN-1:0] i_rs1_data,
    input  logic [hart_pkg::XLEN-1:0] i_rs2_data,
    output logic [hart_pkg::XLEN-1:0] o_alu_result,
    output logic                      o_take
);

    logic [hart_pkg::XLEN-1:0] op_a;
    logic [hart_pkg::XLEN-1:0] op_b;
    logic [4:0]                shamt;
    logic                      eq;
    logic                      br_take;

    always_comb begin
        case (i_ctrl.op_a_sel)
            hart_pkg::OPA_ZERO:      op_a = '0;             // LUI
            hart_pkg::OPA_PC:        op_a = i_pc;           // AUIPC
            hart_pkg::OPA_PC_PLUS_4: op_a = i_pc + 32'd4;   // Jump link
            default:                 op_a = i_rs1_data;
        endcase
    end

    // Jumps add zero so the link value passes straight through
    assign op_b  = (i_ctrl.is_jal || i_ctrl.is_jalr) ? '0 :
                   (i_ctrl.op_b_is_imm ? i_imm : i_rs2_data);
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_ctrl.alu_op)
            hart_pkg::ALU_SUB:  o_alu_result = op_a - op_b;
            hart_pkg::ALU_SLL:  o_alu_result = op_a << shamt;
            hart_pkg::ALU_SLT:  o_alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            hart_pkg::ALU_SLTU: o_alu_result = {31'b0, op_a < op_b};
            hart_pkg::ALU_XOR:  o_alu_result = op_a ^ op_b;
            hart_pkg::ALU_SRL:  o_alu_result = op_a >> shamt;
            hart_pkg::ALU_SRA:  o_alu_result = $signed(op_a) >>> shamt;
            hart_pkg::ALU_OR:   o_alu_result = op_a | op_b;
            hart_pkg::ALU_AND:  o_alu_result = op_a & op_b;
            default:            o_alu_result = op_a + op_b;
        endcase
    end

    assign eq = (op_a == op_b);

    // Less-than comes from bit 0 of the slt/sltu result
    always_comb begin
        case (i_ctrl.br_funct3)
            3'b000:         br_take = eq;                 // beq
            3'b001:         br_take = ~eq;                // bne
            3'b100, 3'b110: br_take = o_alu_result[0];    // blt, bltu
            3'b101, 3'b111: br_take = ~o_alu_result[0];   // bge, bgeu
            default:        br_take = 1'b0;
        endcase
    end

    assign o_take = i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && br_take);

endmodule

// ==== source/hart_fetch.sv ====
/*
  Program counter and next-pc choice. The pc moves once per cycle and
  holds on ebreak. Jump targets with bit 1 set are not supported.
*/
`timescale 1ns/1ps

module hart_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  hart_pkg::ctrl_t           i_ctrl,
    input  logic                      i_take,
    input  logic [hart_pkg::XLEN-1:0] i_imm,
    input  logic [hart_pkg::XLEN-1:0] i_rs1_data,
    output logic [hart_pkg::XLEN-1:0] o_pc,
    output logic [hart_pkg::XLEN-1:0] o_next_pc
);

    logic [hart_pkg::XLEN-1:0] pc_q;
    logic [hart_pkg::XLEN-1:0] target;

    // JALR drops bit 0 of rs1 + imm, branches and JAL are pc relative
    assign target = i_ctrl.is_jalr ? ((i_rs1_data + i_imm) & ~32'd1) : (pc_q + i_imm);

    assign o_next_pc = i_ctrl.halt ? pc_q :            // ebreak parks here
                       (i_take ? target : pc_q + 32'd4);

    always_ff @(posedge clk) begin
        if (rst_n)
            pc_q <= hart_pkg::RESET_ADDR;
        else
            pc_q <= o_next_pc;
    end

    assign o_pc = pc_q;  // Also the imem read address

    // Targets come from decode, regfile and execute together
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst_n) pc_q[1:0] == 2'b00);

endmodule

// ==== source/hart_lsu.sv ====
/*
  Builds the word-aligned data port request. Half and word accesses must
  be naturally aligned. ren and wen stay low during reset.
*/
`timescale 1ns/1ps

module hart_lsu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  hart_pkg::ctrl_t           i_ctrl,
    input  logic [hart_pkg::XLEN-1:0] i_addr,
    input  logic [hart_pkg::XLEN-1:0] i_rs2_data,
    output hart_pkg::dmem_req_t       o_dmem_req
);

    logic [3:0]                lane_mask;
    logic [hart_pkg::XLEN-1:0] lane_data;

    // Lane select from size and low address bits
    always_comb begin
        case (i_ctrl.size)
            hart_pkg::SIZE_BYTE: begin
                lane_mask = 4'b0001 << i_addr[1:0];
                lane_data = {24'b0, i_rs2_data[7:0]} << {i_addr[1:0], 3'b000};
            end
            hart_pkg::SIZE_HALF: begin
                lane_mask = i_addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {16'b0, i_rs2_data[15:0]} << {i_addr[1], 4'b0000};
            end
            default: begin
                lane_mask = 4'b1111;
                lane_data = i_rs2_data;
            end
        endcase
    end

    assign o_dmem_req.addr  = {i_addr[31:2], 2'b00};
    assign o_dmem_req.ren   = i_ctrl.mem_ren && !rst_n;
    assign o_dmem_req.wen   = i_ctrl.mem_wen && !rst_n;
    assign o_dmem_req.wdata = i_ctrl.mem_wen ? lane_data : '0;  // Other lanes zero
    assign o_dmem_req.mask  = (i_ctrl.mem_ren || i_ctrl.mem_wen) ? lane_mask : 4'b0000;

    a_ren_wen_excl: assert property (@(posedge clk) disable iff (rst_n)
        !(o_dmem_req.ren && o_dmem_req.wen));

    // Address comes from rs1 + imm, so alignment is up to the program
    a_half_aligned: assert property (@(posedge clk) disable iff (rst_n)
        (o_dmem_req.ren || o_dmem_req.wen) && i_ctrl.size == hart_pkg::SIZE_HALF
        |-> !i_addr[0]);
    a_word_aligned: assert property (@(posedge clk) disable iff (rst_n)
        (o_dmem_req.ren || o_dmem_req.wen) && i_ctrl.size == hart_pkg::SIZE_WORD
        |-> i_addr[1:0] == 2'b00);

endmodule

// ==== source/hart_pkg.sv ====
/*
  Shared encodings and packed structs of the single-cycle RV32I hart.
  Halves and words must be naturally aligned. There is no trap path.
*/
package hart_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_0000;  // First fetch address

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;  // Only ebreak is acted on

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Operand A source
    typedef enum logic [1:0] {
        OPA_RS1, OPA_ZERO, OPA_PC, OPA_PC_PLUS_4
    } op_a_sel_e;

    // Same code as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE, SIZE_HALF, SIZE_WORD
    } size_e;

    typedef struct packed {
        alu_op_e     alu_op;
        op_a_sel_e   op_a_sel;
        logic        op_b_is_imm;    // Else rs2
        logic        is_branch;
        logic [2:0]  br_funct3;      // Branch condition
        logic        is_jal;
        logic        is_jalr;
        logic        mem_ren;
        logic        mem_wen;
        size_e       size;
        logic        load_unsigned;  // lbu, lhu
        logic        rd_wen;
        logic        halt;           // ebreak
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;   // Word aligned
        logic            ren;
        logic            wen;
        logic [XLEN-1:0] wdata;  // Already placed in its lane
        logic [3:0]      mask;   // One bit per byte lane
    } dmem_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  halt;
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       next_pc;
        logic [REG_ADDR_W-1:0] rd_waddr;  // Zero when nothing is written
        logic [XLEN-1:0]       rd_wdata;
    } retire_t;

endpackage

// ==== source/hart_regfile.sv ====
/*
  31 general registers plus a hardwired x0. Reads are combinational;
  a write lands at the next edge with no bypass to the same-cycle read.
*/
`timescale 1ns/1ps

module hart_regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [hart_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [hart_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [hart_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic                            i_rd_wen,
    input  logic [hart_pkg::XLEN-1:0]       i_rd_data,
    output logic [hart_pkg::XLEN-1:0]       o_rs1_data,
    output logic [hart_pkg::XLEN-1:0]       o_rs2_data
);

    logic [hart_pkg::XLEN-1:0] regs [1:31];  // No storage for x0

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && i_rd_addr != '0) begin  // x0 writes dropped
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// ==== source/hart_result.sv ====
/*
  Load extension, writeback select and retire report.
  Retire valid and rd writes stay off until a reset has been seen and released.
*/
`timescale 1ns/1ps

module hart_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  hart_pkg::ctrl_t           i_ctrl,
    input  logic [hart_pkg::XLEN-1:0] i_inst,
    input  logic [hart_pkg::XLEN-1:0] i_pc,
    input  logic [hart_pkg::XLEN-1:0] i_next_pc,
    input  logic [hart_pkg::XLEN-1:0] i_alu_result,
    input  logic [hart_pkg::XLEN-1:0] i_dmem_rdata,
    output logic                      o_rd_wen,
    output logic [hart_pkg::XLEN-1:0] o_rd_data,
    output hart_pkg::retire_t         o_retire
);

    logic                      rst_seen_q;
    logic                      valid;
    logic [hart_pkg::XLEN-1:0] lane;
    logic [hart_pkg::XLEN-1:0] load_val;

    always_ff @(posedge clk) begin
        if (rst_n)
            rst_seen_q <= 1'b1;  // Sticky once reset has been applied
    end

    assign valid = rst_seen_q && !rst_n;

    assign lane = i_dmem_rdata >> {i_alu_result[1:0], 3'b000};  // Selected lane to bit 0

    always_comb begin
        case (i_ctrl.size)
            hart_pkg::SIZE_BYTE: load_val = {{24{lane[7] & ~i_ctrl.load_unsigned}}, lane[7:0]};
            hart_pkg::SIZE_HALF: load_val = {{16{lane[15] & ~i_ctrl.load_unsigned}}, lane[15:0]};
            default:             load_val = i_dmem_rdata;
        endcase
    end

    assign o_rd_data = i_ctrl.mem_ren ? load_val : i_alu_result;
    assign o_rd_wen  = i_ctrl.rd_wen && valid;

    assign o_retire.valid    = valid;
    assign o_retire.halt     = i_ctrl.halt;
    assign o_retire.inst     = i_inst;
    assign o_retire.pc       = i_pc;
    assign o_retire.next_pc  = i_next_pc;
    assign o_retire.rd_waddr = o_rd_wen ? i_inst[11:7] : '0;
    assign o_retire.rd_wdata = o_rd_data;

endmodule

// ==== source/hart_top.sv ====
/*
  Single-cycle RV32I hart. imem and dmem reads must return in the same
  cycle; register and memory writes land at the next rising edge.
*/
`timescale 1ns/1ps

module hart_top (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [hart_pkg::XLEN-1:0] o_imem_raddr,
    input  logic [hart_pkg::XLEN-1:0] i_imem_rdata,
    output hart_pkg::dmem_req_t       o_dmem_req,
    input  logic [hart_pkg::XLEN-1:0] i_dmem_rdata,
    output hart_pkg::retire_t         o_retire
);

    hart_pkg::ctrl_t           ctrl;
    logic [hart_pkg::XLEN-1:0] imm;
    logic [hart_pkg::XLEN-1:0] pc;
    logic [hart_pkg::XLEN-1:0] next_pc;
    logic [hart_pkg::XLEN-1:0] rs1_data;
    logic [hart_pkg::XLEN-1:0] rs2_data;
    logic [hart_pkg::XLEN-1:0] alu_result;
    logic                      take;
    logic                      rd_wen;
    logic [hart_pkg::XLEN-1:0] rd_data;

    assign o_imem_raddr = pc;

    hart_fetch i_hart_fetch (
        .clk, .rst_n, .i_ctrl(ctrl), .i_take(take), .i_imm(imm),
        .i_rs1_data(rs1_data), .o_pc(pc), .o_next_pc(next_pc)
    );

    hart_decode i_hart_decode (.i_inst(i_imem_rdata), .o_ctrl(ctrl), .o_imm(imm));

    hart_regfile i_hart_regfile (
        .clk, .rst_n,
        .i_rs1_addr(i_imem_rdata[19:15]), .i_rs2_addr(i_imem_rdata[24:20]),
        .i_rd_addr(i_imem_rdata[11:7]), .i_rd_wen(rd_wen), .i_rd_data(rd_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    hart_execute i_hart_execute (
        .i_ctrl(ctrl), .i_pc(pc), .i_imm(imm), .i_rs1_data(rs1_data),
        .i_rs2_data(rs2_data), .o_alu_result(alu_result), .o_take(take)
    );

    hart_lsu i_hart_lsu (
        .clk, .rst_n, .i_ctrl(ctrl), .i_addr(alu_result),  // Effective address
        .i_rs2_data(rs2_data), .o_dmem_req(o_dmem_req)
    );

    hart_result i_hart_result (
        .clk, .rst_n, .i_ctrl(ctrl), .i_inst(i_imem_rdata), .i_pc(pc),
        .i_next_pc(next_pc), .i_alu_result(alu_result), .i_dmem_rdata(i_dmem_rdata),
        .o_rd_wen(rd_wen), .o_rd_data(rd_data), .o_retire(o_retire)
    );

endmodule
